// File: verilog/fp_noncomp_defines.svh
/* FP32 only. Other formats need new widths and a new canonical NaN */
`ifndef FP_NONCOMP_DEFINES_SVH
`define FP_NONCOMP_DEFINES_SVH

// Word layout
`define FP_WIDTH      32
`define FP_EXP_BITS   8
`define FP_MAN_BITS   23

// One bit per FCLASS category
`define FP_CLASS_BITS 10

// Positive quiet NaN with only the top mantissa bit set
`define FP_QNAN       32'h7FC00000

`endif

// File: verilog/fp_format_pkg.sv
/* FP32 number format only. Operand info carries no NaN-boxing flag */
`include "fp_noncomp_defines.svh"

package fp_format_pkg;

  // IEEE 754 single precision, sign in the MSB
  typedef struct packed {
    logic                    sign;
    logic [`FP_EXP_BITS-1:0] exponent;
    logic [`FP_MAN_BITS-1:0] mantissa;
  } fp_t;

  // Result word, either a float or an integer boolean in bit 0
  typedef union packed {
    fp_t                  fp;
    logic [`FP_WIDTH-1:0] raw;
  } fp_word_u;

  // Operand category, exactly one of the first five is set
  typedef struct packed {
    logic is_normal;
    logic is_subnormal;
    logic is_zero;
    logic is_inf;
    logic is_nan;
    logic is_signalling;
    logic is_quiet;
  } fp_info_t;

  // Exception flags, invalid down to inexact
  typedef struct packed {
    logic NV;
    logic DZ;
    logic OF;
    logic UF;
    logic NX;
  } status_t;

  // One-hot class mask, same bit order as RISC-V FCLASS
  typedef enum logic [`FP_CLASS_BITS-1:0] {
    NEGINF     = 10'b00_0000_0001,
    NEGNORM    = 10'b00_0000_0010,
    NEGSUBNORM = 10'b00_0000_0100,
    NEGZERO    = 10'b00_0000_1000,
    POSZERO    = 10'b00_0001_0000,
    POSSUBNORM = 10'b00_0010_0000,
    POSNORM    = 10'b00_0100_0000,
    POSINF     = 10'b00_1000_0000,
    SNAN       = 10'b01_0000_0000,
    QNAN       = 10'b10_0000_0000
  } classmask_e;

endpackage

// File: verilog/fp_noncomp_pkg.sv
/* The rm field picks the sub-operation. rm values 4 to 7 are illegal and give zero results */
package fp_noncomp_pkg;

  // Operation group
  typedef enum logic [1:0] {
    SGNJ     = 2'd0,
    MINMAX   = 2'd1,
    CMP      = 2'd2,
    CLASSIFY = 2'd3
  } op_e;

  // Sub-operation, named after the rounding mode it reuses
  // RNE: SGNJ, MIN or LE
  // RTZ: SGNJN, MAX or LT
  // RDN: SGNJX or EQ
  // RUP: sign-injection passthrough
  typedef enum logic [2:0] {
    RNE = 3'd0,
    RTZ = 3'd1,
    RDN = 3'd2,
    RUP = 3'd3
  } rm_e;

endpackage

// File: verilog/fp_operand_stage.sv
/* Data registers only load with in_valid_i and hold stale values in idle cycles */
`timescale 1ns/1ps

module fp_operand_stage (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  fp_format_pkg::fp_t   a_i,
  input  fp_format_pkg::fp_t   b_i,
  input  fp_noncomp_pkg::op_e  op_i,
  input  fp_noncomp_pkg::rm_e  rm_i,
  input  logic                 op_mod_i,
  input  logic                 in_valid_i,
  output fp_format_pkg::fp_t   a_o,
  output fp_format_pkg::fp_t   b_o,
  output fp_noncomp_pkg::op_e  op_o,
  output fp_noncomp_pkg::rm_e  rm_o,
  output logic                 op_mod_o,
  output logic                 valid_o
);

  // Stage valid, follows the input strobe every cycle
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= in_valid_i;
    end
  end

  // Payload, captured only for accepted operations
  always_ff @(posedge clk_i) begin
    if (in_valid_i) begin
      a_o      <= a_i;
      b_o      <= b_i;
      op_o     <= op_i;
      rm_o     <= rm_i;
      op_mod_o <= op_mod_i;
    end
  end

endmodule

// File: verilog/fp_classifier.sv
/* Combinational. NaN class ignores the sign, quiet means top mantissa bit set */
`timescale 1ns/1ps
`include "fp_noncomp_defines.svh"

module fp_classifier (
  input  fp_format_pkg::fp_t         a_i,
  input  fp_format_pkg::fp_t         b_i,
  output fp_format_pkg::fp_info_t    info_a_o,
  output fp_format_pkg::fp_info_t    info_b_o,
  output fp_format_pkg::classmask_e  class_mask_o
);

  // Category flags of one operand
  function automatic fp_format_pkg::fp_info_t classify(input fp_format_pkg::fp_t x);
    fp_format_pkg::fp_info_t info;
    logic                    exp_ones;
    logic                    exp_zero;
    logic                    man_zero;
    exp_ones           = &x.exponent;
    exp_zero           = ~|x.exponent;
    man_zero           = ~|x.mantissa;
    info.is_normal     = !exp_ones && !exp_zero;
    info.is_subnormal  = exp_zero && !man_zero;
    info.is_zero       = exp_zero && man_zero;
    info.is_inf        = exp_ones && man_zero;
    info.is_nan        = exp_ones && !man_zero;
    // NaN kind from the quiet bit
    info.is_signalling = info.is_nan && !x.mantissa[`FP_MAN_BITS-1];
    info.is_quiet      = info.is_nan && x.mantissa[`FP_MAN_BITS-1];
    return info;
  endfunction

  assign info_a_o = classify(a_i);
  assign info_b_o = classify(b_i);

  // --------------------
  // FCLASS mask of a
  always_comb begin
    if (info_a_o.is_normal) begin
      class_mask_o = a_i.sign ? fp_format_pkg::NEGNORM : fp_format_pkg::POSNORM;
    end else if (info_a_o.is_subnormal) begin
      class_mask_o = a_i.sign ? fp_format_pkg::NEGSUBNORM : fp_format_pkg::POSSUBNORM;
    end else if (info_a_o.is_zero) begin
      class_mask_o = a_i.sign ? fp_format_pkg::NEGZERO : fp_format_pkg::POSZERO;
    end else if (info_a_o.is_inf) begin
      class_mask_o = a_i.sign ? fp_format_pkg::NEGINF : fp_format_pkg::POSINF;
    end else begin
      // Only NaN is left here
      class_mask_o = info_a_o.is_signalling ? fp_format_pkg::SNAN : fp_format_pkg::QNAN;
    end
  end

endmodule

// File: verilog/fp_sign_inject.sv
/* Combinational. Never raises flags, illegal rm gives a zero word */
`timescale 1ns/1ps

module fp_sign_inject (
  input  fp_format_pkg::fp_t        a_i,
  input  fp_format_pkg::fp_t        b_i,
  input  fp_noncomp_pkg::rm_e       rm_i,
  input  logic                      op_mod_i,
  output fp_format_pkg::fp_word_u   result_o,
  output logic                      ext_bit_o
);

  fp_format_pkg::fp_t sgnj;

  // Magnitude of a, sign chosen by rm
  always_comb begin
    sgnj = a_i;
    case (rm_i)
      fp_noncomp_pkg::RNE: sgnj.sign = b_i.sign;
      fp_noncomp_pkg::RTZ: sgnj.sign = ~b_i.sign;
      fp_noncomp_pkg::RDN: sgnj.sign = a_i.sign ^ b_i.sign;
      fp_noncomp_pkg::RUP: sgnj      = a_i;
      default:             sgnj      = '0;
    endcase
  end

  assign result_o.fp = sgnj;

  // Sign-extend into an integer register when op_mod is set
  assign ext_bit_o = op_mod_i ? sgnj.sign : 1'b1;

endmodule

// File: verilog/fp_compare_unit.sv
/* Combinational. Min/max is quiet (only sNaN flags NV), LE/LT signal on any NaN */
`timescale 1ns/1ps
`include "fp_noncomp_defines.svh"

module fp_compare_unit (
  input  fp_format_pkg::fp_t        a_i,
  input  fp_format_pkg::fp_t        b_i,
  input  fp_format_pkg::fp_info_t   info_a_i,
  input  fp_format_pkg::fp_info_t   info_b_i,
  input  fp_noncomp_pkg::rm_e       rm_i,
  input  logic                      op_mod_i,
  output fp_format_pkg::fp_word_u   minmax_o,
  output fp_format_pkg::fp_word_u   cmp_o,
  output fp_format_pkg::status_t    minmax_status_o,
  output fp_format_pkg::status_t    cmp_status_o
);

  logic any_nan;
  logic any_snan;
  logic a_smaller;
  logic equal;
  logic cmp_bit;

  // --------------------
  // Shared ordering
  assign any_nan  = info_a_i.is_nan | info_b_i.is_nan;
  assign any_snan = info_a_i.is_signalling | info_b_i.is_signalling;
  // Sign-magnitude order from an unsigned compare, flipped once a sign is set
  assign a_smaller = (a_i < b_i) ^ (a_i.sign | b_i.sign);
  // +0 and -0 are equal
  assign equal     = (a_i == b_i) | (info_a_i.is_zero & info_b_i.is_zero);

  // --------------------
  // Min / max
  always_comb begin
    minmax_status_o    = '0;
    minmax_status_o.NV = any_snan;
    if (info_a_i.is_nan && info_b_i.is_nan) begin
      minmax_o.raw = `FP_QNAN;
    end else if (info_a_i.is_nan) begin
      minmax_o.fp = b_i;
    end else if (info_b_i.is_nan) begin
      minmax_o.fp = a_i;
    end else begin
      case (rm_i)
        fp_noncomp_pkg::RNE: minmax_o.fp = a_smaller ? a_i : b_i;
        fp_noncomp_pkg::RTZ: minmax_o.fp = a_smaller ? b_i : a_i;
        default:             minmax_o.raw = '0;
      endcase
    end
  end

  // --------------------
  // Comparisons, op_mod inverts the boolean
  always_comb begin
    cmp_bit      = 1'b0;
    cmp_status_o = '0;
    if (any_snan) begin
      cmp_status_o.NV = 1'b1;
    end else begin
      case (rm_i)
        fp_noncomp_pkg::RNE: begin
          if (any_nan) cmp_status_o.NV = 1'b1;
          else cmp_bit = (a_smaller | equal) ^ op_mod_i;
        end
        fp_noncomp_pkg::RTZ: begin
          if (any_nan) cmp_status_o.NV = 1'b1;
          else cmp_bit = (a_smaller & ~equal) ^ op_mod_i;
        end
        // Quiet NaN is unequal to everything
        fp_noncomp_pkg::RDN: cmp_bit = any_nan ? op_mod_i : (equal ^ op_mod_i);
        default:             cmp_bit = 1'b0;
      endcase
    end
  end

  // Boolean in bit 0 of an integer word
  assign cmp_o.raw = {{(`FP_WIDTH-1){1'b0}}, cmp_bit};

endmodule

// File: verilog/fp_result_stage.sv
/* No back-pressure. Each registered result is offered for exactly one cycle */
`timescale 1ns/1ps

module fp_result_stage (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  input  logic                       valid_i,
  input  fp_noncomp_pkg::op_e        op_i,
  input  fp_format_pkg::fp_word_u    sgnj_i,
  input  fp_format_pkg::fp_word_u    minmax_i,
  input  fp_format_pkg::fp_word_u    cmp_i,
  input  logic                       sgnj_ext_i,
  input  fp_format_pkg::status_t     minmax_status_i,
  input  fp_format_pkg::status_t     cmp_status_i,
  input  fp_format_pkg::classmask_e  class_mask_i,
  output fp_format_pkg::fp_word_u    result_o,
  output fp_format_pkg::status_t     status_o,
  output logic                       extension_bit_o,
  output fp_format_pkg::classmask_e  class_mask_o,
  output logic                       is_class_o,
  output logic                       out_valid_o,
  output logic                       busy_o
);

  fp_format_pkg::fp_word_u result_d;
  fp_format_pkg::status_t  status_d;
  logic                    ext_d;
  logic                    is_class_d;

  // --------------------
  // Select by op group
  always_comb begin
    // Classification leaves word and flags at zero
    result_d = '0;
    status_d = '0;
    ext_d    = 1'b0;
    case (op_i)
      fp_noncomp_pkg::SGNJ: begin
        result_d = sgnj_i;
        ext_d    = sgnj_ext_i;
      end
      fp_noncomp_pkg::MINMAX: begin
        result_d = minmax_i;
        status_d = minmax_status_i;
        ext_d    = 1'b1;  // float result, NaN-box upper bits
      end
      fp_noncomp_pkg::CMP: begin
        result_d = cmp_i;
        status_d = cmp_status_i;
      end
      default: ext_d = 1'b0;
    endcase
  end

  assign is_class_d = (op_i == fp_noncomp_pkg::CLASSIFY);

  // --------------------
  // Output registers
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      result_o        <= '0;
      status_o        <= '0;
      extension_bit_o <= 1'b0;
      class_mask_o    <= fp_format_pkg::classmask_e'(0);
      is_class_o      <= 1'b0;
      out_valid_o     <= 1'b0;
    end else begin
      out_valid_o <= valid_i;
      // Hold last result over bubbles
      if (valid_i) begin
        result_o        <= result_d;
        status_o        <= status_d;
        extension_bit_o <= ext_d;
        class_mask_o    <= class_mask_i;
        is_class_o      <= is_class_d;
      end
    end
  end

  // In flight in either register stage
  assign busy_o = valid_i | out_valid_o;

endmodule

// File: verilog/fp_noncomp_top.sv
/* FP32 non-computational unit, fixed 2-cycle latency. Downstream must accept every cycle */
`timescale 1ns/1ps

module fp_noncomp_top (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  input  fp_format_pkg::fp_t         a_i,
  input  fp_format_pkg::fp_t         b_i,
  input  fp_noncomp_pkg::op_e        op_i,
  input  fp_noncomp_pkg::rm_e        rm_i,
  input  logic                       op_mod_i,
  input  logic                       in_valid_i,
  output fp_format_pkg::fp_word_u    result_o,
  output fp_format_pkg::status_t     status_o,
  output logic                       extension_bit_o,
  output fp_format_pkg::classmask_e  class_mask_o,
  output logic                       is_class_o,
  output logic                       out_valid_o,
  output logic                       busy_o
);

  // Stage 1 outputs
  fp_format_pkg::fp_t        a_q;
  fp_format_pkg::fp_t        b_q;
  fp_noncomp_pkg::op_e       op_q;
  fp_noncomp_pkg::rm_e       rm_q;
  logic                      op_mod_q;
  logic                      valid_q;
  // Combinational results between the stages
  fp_format_pkg::fp_info_t   info_a;
  fp_format_pkg::fp_info_t   info_b;
  fp_format_pkg::classmask_e class_mask;
  fp_format_pkg::fp_word_u   sgnj_word;
  logic                      sgnj_ext;
  fp_format_pkg::fp_word_u   minmax_word;
  fp_format_pkg::fp_word_u   cmp_word;
  fp_format_pkg::status_t    minmax_status;
  fp_format_pkg::status_t    cmp_status;

  fp_operand_stage u_operand_stage (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .a_i        (a_i),
    .b_i        (b_i),
    .op_i       (op_i),
    .rm_i       (rm_i),
    .op_mod_i   (op_mod_i),
    .in_valid_i (in_valid_i),
    .a_o        (a_q),
    .b_o        (b_q),
    .op_o       (op_q),
    .rm_o       (rm_q),
    .op_mod_o   (op_mod_q),
    .valid_o    (valid_q)
  );

  fp_classifier u_classifier (
    .a_i          (a_q),
    .b_i          (b_q),
    .info_a_o     (info_a),
    .info_b_o     (info_b),
    .class_mask_o (class_mask)
  );

  fp_sign_inject u_sign_inject (
    .a_i       (a_q),
    .b_i       (b_q),
    .rm_i      (rm_q),
    .op_mod_i  (op_mod_q),
    .result_o  (sgnj_word),
    .ext_bit_o (sgnj_ext)
  );

  fp_compare_unit u_compare_unit (
    .a_i             (a_q),
    .b_i             (b_q),
    .info_a_i        (info_a),
    .info_b_i        (info_b),
    .rm_i            (rm_q),
    .op_mod_i        (op_mod_q),
    .minmax_o        (minmax_word),
    .cmp_o           (cmp_word),
    .minmax_status_o (minmax_status),
    .cmp_status_o    (cmp_status)
  );

  fp_result_stage u_result_stage (
    .clk_i           (clk_i),
    .arst_n_i        (arst_n_i),
    .valid_i         (valid_q),
    .op_i            (op_q),
    .sgnj_i          (sgnj_word),
    .minmax_i        (minmax_word),
    .cmp_i           (cmp_word),
    .sgnj_ext_i      (sgnj_ext),
    .minmax_status_i (minmax_status),
    .cmp_status_i    (cmp_status),
    .class_mask_i    (class_mask),
    .result_o        (result_o),
    .status_o        (status_o),
    .extension_bit_o (extension_bit_o),
    .class_mask_o    (class_mask_o),
    .is_class_o      (is_class_o),
    .out_valid_o     (out_valid_o),
    .busy_o          (busy_o)
  );

endmodule

// File: sim/fp_noncomp_tb.sv
/* Self-checking testbench for the FP32 unit. Results are due two rising edges after the strobe
   is driven, and the downstream side is always ready */
`timescale 1ns/1ps
`include "fp_noncomp_defines.svh"

module fp_noncomp_tb;

  // Expected outputs of one operation plus the cycle it must show up
  typedef struct packed {
    logic [31:0] result;
    logic [4:0]  status;
    logic        ext;
    logic [9:0]  mask;
    logic        is_class;
    int          due;
  } expect_t;

  localparam int LATENCY = 2;
  localparam int N_GAPPED = 24 + 15 + 30 + 10;
  localparam int N_STREAM = 40;
  // Reset, gapped vectors, streaming, drain per test, margin
  localparam int LIMIT = 3 + 2 * N_GAPPED + N_STREAM + 5 * (LATENCY + 4) + 20;
  // One operand per class in FCLASS bit order
  localparam logic [31:0] CLASS_VALS [10] = '{
    32'hff800000, 32'hbf800000, 32'h80000456, 32'h80000000, 32'h00000000,
    32'h00000123, 32'h3f800000, 32'h7f800000, 32'h7f800001, 32'h7fc00000
  };

  logic                      clk;
  logic                      arst_n_i;
  fp_format_pkg::fp_t        a_i;
  fp_format_pkg::fp_t        b_i;
  fp_noncomp_pkg::op_e       op_i;
  fp_noncomp_pkg::rm_e       rm_i;
  logic                      op_mod_i;
  logic                      in_valid_i;
  fp_format_pkg::fp_word_u   result_o;
  fp_format_pkg::status_t    status_o;
  logic                      extension_bit_o;
  fp_format_pkg::classmask_e class_mask_o;
  logic                      is_class_o;
  logic                      out_valid_o;
  logic                      busy_o;

  expect_t exp_q[$];
  int      cycles = 0;
  int      err_count = 0;
  int      check_count = 0;

  fp_noncomp_top UUT (
    .clk_i           (clk),
    .arst_n_i        (arst_n_i),
    .a_i             (a_i),
    .b_i             (b_i),
    .op_i            (op_i),
    .rm_i            (rm_i),
    .op_mod_i        (op_mod_i),
    .in_valid_i      (in_valid_i),
    .result_o        (result_o),
    .status_o        (status_o),
    .extension_bit_o (extension_bit_o),
    .class_mask_o    (class_mask_o),
    .is_class_o      (is_class_o),
    .out_valid_o     (out_valid_o),
    .busy_o          (busy_o)
  );

  // --------------------
  // Clock, cycle count, run limit
  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) cycles <= cycles + 1;

  initial begin
    while (cycles < LIMIT) @(posedge clk);
    $display("timeout: no end of run after %0d cycles, results still pending", LIMIT);
    $display("tests failed");
    $finish;
  end

  // Compare one value and log a mismatch
  task automatic check(input string name, input logic [31:0] expv, input logic [31:0] actv);
    check_count++;
    if (expv !== actv) begin
      err_count++;
      $display("error t=%0t %s expected %h got %h", $time, name, expv, actv);
    end
  endtask

  // --------------------
  // Reference model
  function automatic logic [9:0] class_of(input logic [31:0] x);
    int   idx;
    logic exp_max;
    logic exp_min;
    logic man_nz;
    exp_max = (x[30:23] == 8'hff);
    exp_min = (x[30:23] == 8'h00);
    man_nz  = (x[22:0] != 23'd0);
    if (exp_max && man_nz) idx = x[22] ? 9 : 8;
    else if (exp_max) idx = x[31] ? 0 : 7;
    else if (!exp_min) idx = x[31] ? 1 : 6;
    else if (man_nz) idx = x[31] ? 2 : 5;
    else idx = x[31] ? 3 : 4;
    return 10'b1 << idx;
  endfunction

  function automatic expect_t ref_noncomp(input logic [31:0] a, input logic [31:0] b,
                                          input logic [1:0] op, input logic [2:0] rm,
                                          input logic mod);
    expect_t e;
    logic    nan_a;
    logic    nan_b;
    logic    snan;
    logic    lt;
    logic    eq;
    logic    r;
    nan_a = (a[30:23] == 8'hff) && (a[22:0] != 23'd0);
    nan_b = (b[30:23] == 8'hff) && (b[22:0] != 23'd0);
    snan  = (nan_a && !a[22]) || (nan_b && !b[22]);
    // Order by sign first, then by magnitude
    if (a[31] != b[31]) lt = a[31];
    else if (a[31]) lt = a[30:0] > b[30:0];
    else lt = a[30:0] < b[30:0];
    eq = (a == b) || (a[30:0] == 31'd0 && b[30:0] == 31'd0);
    r  = 1'b0;
    e  = '0;
    e.mask     = class_of(a);
    e.is_class = (op == 2'd3);
    case (op)
      2'd0: begin
        if (rm == 3'd0) e.result = {b[31], a[30:0]};
        else if (rm == 3'd1) e.result = {~b[31], a[30:0]};
        else if (rm == 3'd2) e.result = {a[31] ^ b[31], a[30:0]};
        else if (rm == 3'd3) e.result = a;
        e.ext = mod ? e.result[31] : 1'b1;
      end
      2'd1: begin
        e.status[4] = snan;
        e.ext       = 1'b1;
        if (nan_a && nan_b) e.result = `FP_QNAN;
        else if (nan_a) e.result = b;
        else if (nan_b) e.result = a;
        else if (rm == 3'd0) e.result = lt ? a : b;
        else if (rm == 3'd1) e.result = lt ? b : a;
      end
      2'd2: begin
        if (snan || ((rm == 3'd0 || rm == 3'd1) && (nan_a || nan_b))) e.status[4] = 1'b1;
        else if (rm == 3'd2 && (nan_a || nan_b)) r = mod;
        else if (rm == 3'd0) r = (lt || eq) ^ mod;
        else if (rm == 3'd1) r = (lt && !eq) ^ mod;
        else if (rm == 3'd2) r = eq ^ mod;
        e.result = {31'd0, r};
      end
      default: e.result = 32'd0;
    endcase
    return e;
  endfunction

  // --------------------
  // Stimulus helpers
  task automatic send(input logic [31:0] a, input logic [31:0] b, input int op, input int rm,
                      input int mod, input bit gap);
    expect_t e;
    @(negedge clk);
    a_i        = a;
    b_i        = b;
    op_i       = fp_noncomp_pkg::op_e'(op[1:0]);
    rm_i       = fp_noncomp_pkg::rm_e'(rm[2:0]);
    op_mod_i   = mod[0];
    in_valid_i = 1'b1;
    e          = ref_noncomp(a, b, op[1:0], rm[2:0], mod[0]);
    e.due      = cycles + LATENCY;
    exp_q.push_back(e);
    if (gap) begin
      @(negedge clk);
      in_valid_i = 1'b0;
    end
  endtask

  // Wait until every result of a test is back, then log it
  task automatic finish_test(input string name, input int nvec, input int start_err);
    @(negedge clk);
    in_valid_i = 1'b0;
    while (exp_q.size() != 0) @(negedge clk);
    @(negedge clk);
    $display("test %s: %0d vectors, %0d errors", name, nvec, err_count - start_err);
  endtask

  // --------------------
  // Compare process samples settled outputs at the falling edge
  always @(negedge clk) begin
    expect_t e;
    logic    exp_valid;
    exp_valid = (exp_q.size() > 0) && (exp_q[0].due == cycles);
    check("out_valid_o", 32'(exp_valid), 32'(out_valid_o));
    // Busy while a strobe sits in either register stage
    check("busy_o", 32'((exp_q.size() > 0) && (exp_q[0].due <= cycles + 1)), 32'(busy_o));
    if (out_valid_o && exp_q.size() > 0) begin
      e = exp_q.pop_front();
      check("result_o", e.result, result_o.raw);
      check("status_o", 32'(e.status), 32'(status_o));
      check("extension_bit_o", 32'(e.ext), 32'(extension_bit_o));
      check("class_mask_o", 32'(e.mask), 32'(class_mask_o));
      check("is_class_o", 32'(e.is_class), 32'(is_class_o));
    end else if (out_valid_o) begin
      err_count++;
      $display("error t=%0t result offered with no operation pending", $time);
    end
  end

  initial begin
    logic [31:0] r;
    int          start_err;
    int          op;
    void'($urandom(32'h8d55));
    arst_n_i   = 1'b0;
    a_i        = '0;
    b_i        = '0;
    op_i       = fp_noncomp_pkg::SGNJ;
    rm_i       = fp_noncomp_pkg::RNE;
    op_mod_i   = 1'b0;
    in_valid_i = 1'b0;

    // Reset holds outputs low and zero
    start_err = err_count;
    repeat (2) begin
      @(negedge clk);
      check("out_valid_o", 32'd0, 32'(out_valid_o));
      check("busy_o", 32'd0, 32'(busy_o));
      check("result_o", 32'd0, result_o.raw);
    end
    arst_n_i = 1'b1;
    @(negedge clk);
    check("result_o", 32'd0, result_o.raw);
    $display("test reset: %0d errors", err_count - start_err);

    start_err = err_count;
    for (int rm = 0; rm < 4; rm++)
      for (int mod = 0; mod < 2; mod++)
        repeat (3) send($urandom, $urandom, 0, rm, mod, 1'b1);
    finish_test("sign_injection", 24, start_err);

    // Signed zeros, quiet NaN, both NaN, signalling NaN
    start_err = err_count;
    for (int rm = 0; rm < 2; rm++)
      repeat (4) send($urandom, $urandom, 1, rm, 0, 1'b1);
    send(32'h00000000, 32'h80000000, 1, 0, 0, 1'b1);
    send(32'h80000000, 32'h00000000, 1, 1, 0, 1'b1);
    send(32'h7fc00000, 32'h3f800000, 1, 0, 0, 1'b1);
    send(32'hc0000000, 32'hffc12345, 1, 1, 0, 1'b1);
    send(32'h7fc00000, 32'h7f800001, 1, 0, 0, 1'b1);
    send(32'h7f800001, 32'h3f800000, 1, 1, 0, 1'b1);
    send(32'h7f800000, 32'hff800000, 1, 0, 0, 1'b1);
    finish_test("min_max", 15, start_err);

    start_err = err_count;
    for (int rm = 0; rm < 3; rm++) begin
      for (int mod = 0; mod < 2; mod++) begin
        r = $urandom;
        send($urandom, r, 2, rm, mod, 1'b1);
        send(r, r, 2, rm, mod, 1'b1);
        send(32'h00000000, 32'h80000000, 2, rm, mod, 1'b1);
        send(32'hffc12345, 32'h3f800000, 2, rm, mod, 1'b1);
        send(32'h3f800000, 32'h7f800001, 2, rm, mod, 1'b1);
      end
    end
    finish_test("compare", 30, start_err);

    start_err = err_count;
    for (int k = 0; k < 10; k++) send(CLASS_VALS[k], $urandom, 3, 0, 0, 1'b1);
    finish_test("classify", 10, start_err);

    // Back-to-back mixed operations with some special operands
    start_err = err_count;
    repeat (N_STREAM) begin
      op = $urandom % 4;
      r  = ($urandom % 4 == 0) ? CLASS_VALS[$urandom % 10] : $urandom;
      send(r, $urandom, op, (op == 0) ? $urandom % 4 : (op == 1) ? $urandom % 2 :
           (op == 2) ? $urandom % 3 : 0, $urandom % 2, 1'b0);
    end
    finish_test("streaming", N_STREAM, start_err);

    $display("checks %0d, errors %0d", check_count, err_count);
    if (err_count == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// File: src.f
+incdir+verilog
verilog/fp_format_pkg.sv
verilog/fp_noncomp_pkg.sv
verilog/fp_operand_stage.sv
verilog/fp_classifier.sv
verilog/fp_sign_inject.sv
verilog/fp_compare_unit.sv
verilog/fp_result_stage.sv
verilog/fp_noncomp_top.sv
sim/fp_noncomp_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the FP32 non-computational unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f src.f --top-module fp_noncomp_tb -o fp_noncomp_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

out=$(./obj_dir/fp_noncomp_sim)
rc=$?
printf '%s\n' "$out"
if [ $rc -ne 0 ]; then
  echo "simulation exited with status $rc"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "all tests passed"; then
  exit 0
fi
exit 1
